// ==== hdl/Core_cfg.svh ====
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// Datapath word width.
`define DATA_WIDTH 32

// Register index width, 32 architectural registers.
`define REG_ADDR_WIDTH 5

`endif

// ==== hdl/CorePkg.sv ====
`include "Core_cfg.svh"

package CorePkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Basic datapath types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic [`DATA_WIDTH-1:0] dataWord;
    typedef logic [`REG_ADDR_WIDTH-1:0] regIndex;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Instruction encodings
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [5:0] {
        OP_RTYPE = 6'd0,
        OP_ADDI  = 6'd8,
        OP_ANDI  = 6'd12,
        OP_ORI   = 6'd13,
        OP_LUI   = 6'd15
    } Opcode;

    // Function field, only meaningful with OP_RTYPE.
    typedef enum logic [5:0] {
        FN_SLL = 6'd0,
        FN_SRL = 6'd2,
        FN_ADD = 6'd32,
        FN_SUB = 6'd34,
        FN_AND = 6'd36,
        FN_OR  = 6'd37,
        FN_XOR = 6'd38,
        FN_SLT = 6'd42
    } Funct;

    // Internal ALU selector.
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_LUI
    } AluOp;

endpackage

// ==== hdl/RegFile.sv ====
`timescale 1ns/1ps
`include "Core_cfg.svh"

module RegFile (
    input  logic             clk,
    input  logic             rst,
    input  CorePkg::regIndex readRegister1,
    input  CorePkg::regIndex readRegister2,
    input  CorePkg::regIndex writeRegister,
    input  CorePkg::dataWord writeData,
    input  logic             writeEnable,
    output CorePkg::dataWord readData1,
    output CorePkg::dataWord readData2,

    // Debug access.
    input  CorePkg::regIndex readRegisterDebug,
    output CorePkg::dataWord readDataDebug
);
    import CorePkg::*;

    localparam int regCount = 1 << `REG_ADDR_WIDTH;

    // Register 0 has no storage.
    dataWord memory [regCount-1:1];

    // Shared read path, index 0 is hardwired to zero.
    function automatic dataWord readPort(input regIndex index);
        dataWord value;
        if (index == '0) begin
            value = '0;
        end else begin
            value = memory[index];
        end
        return value;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Combinational reads
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        readData1 = readPort(readRegister1);
        readData2 = readPort(readRegister2);
        readDataDebug = readPort(readRegisterDebug);
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Write port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 1; i < regCount; i++) begin
                memory[i] <= '0;
            end
        end else if (writeEnable && writeRegister != '0) begin
            memory[writeRegister] <= writeData;
        end
    end

endmodule

// ==== hdl/InstrDecoder.sv ====
`timescale 1ns/1ps
`include "Core_cfg.svh"

module InstrDecoder (
    input  CorePkg::dataWord instr,
    output CorePkg::regIndex rs,
    output CorePkg::regIndex rt,
    output CorePkg::regIndex destReg,
    output logic [4:0]       shamt,
    output CorePkg::AluOp    aluOp,
    output logic             useImm,
    output CorePkg::dataWord imm,
    output logic             legal
);
    import CorePkg::*;

    Opcode opcode;
    Funct funct;
    regIndex rd;
    logic [15:0] immField;
    dataWord immSigned;
    dataWord immZero;
    dataWord immUpper;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Field extraction
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign opcode = Opcode'(instr[31:26]);
    assign rs = instr[25:21];
    assign rt = instr[20:16];
    assign rd = instr[15:11];
    assign shamt = instr[10:6];
    assign funct = Funct'(instr[5:0]);
    assign immField = instr[15:0];

    // Immediate forms.
    assign immSigned = {{(`DATA_WIDTH-16){immField[15]}}, immField};
    assign immZero = {{(`DATA_WIDTH-16){1'b0}}, immField};
    assign immUpper = {immField, {(`DATA_WIDTH-16){1'b0}}};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Operation select
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        aluOp = ALU_ADD;
        useImm = 1'b0;
        imm = immSigned;
        destReg = rt;
        legal = 1'b1;
        case (opcode)
            OP_RTYPE: begin
                destReg = rd;
                case (funct)
                    FN_ADD: aluOp = ALU_ADD;
                    FN_SUB: aluOp = ALU_SUB;
                    FN_AND: aluOp = ALU_AND;
                    FN_OR: aluOp = ALU_OR;
                    FN_XOR: aluOp = ALU_XOR;
                    FN_SLT: aluOp = ALU_SLT;
                    FN_SLL: aluOp = ALU_SLL;
                    FN_SRL: aluOp = ALU_SRL;
                    default: legal = 1'b0;
                endcase
            end
            OP_ADDI: begin
                aluOp = ALU_ADD;
                useImm = 1'b1;
                imm = immSigned;
            end
            OP_ANDI: begin
                aluOp = ALU_AND;
                useImm = 1'b1;
                imm = immZero;
            end
            OP_ORI: begin
                aluOp = ALU_OR;
                useImm = 1'b1;
                imm = immZero;
            end
            // Already shifted here, the ALU passes it on.
            OP_LUI: begin
                aluOp = ALU_LUI;
                useImm = 1'b1;
                imm = immUpper;
            end
            default: legal = 1'b0;
        endcase
    end

endmodule

// ==== hdl/Alu.sv ====
`timescale 1ns/1ps
`include "Core_cfg.svh"

module Alu (
    input  CorePkg::dataWord a,
    input  CorePkg::dataWord b,
    input  logic [4:0]       shamt,
    input  CorePkg::AluOp    aluOp,
    output CorePkg::dataWord result
);
    import CorePkg::*;

    dataWord sum;
    dataWord diff;
    logic lessThan;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Arithmetic and compare
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign sum = a + b;
    assign diff = a - b;

    // Signed compare.
    assign lessThan = $signed(a) < $signed(b);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Result select
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        case (aluOp)
            ALU_ADD: begin
                result = sum;
            end
            ALU_SUB: begin
                result = diff;
            end
            ALU_AND: begin
                result = a & b;
            end
            ALU_OR: begin
                result = a | b;
            end
            ALU_XOR: begin
                result = a ^ b;
            end
            ALU_SLT: begin
                result = {{(`DATA_WIDTH-1){1'b0}}, lessThan};
            end
            // Shifts act on rt.
            ALU_SLL: begin
                result = b << shamt;
            end
            ALU_SRL: begin
                result = b >> shamt;
            end
            ALU_LUI: begin
                result = b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// ==== hdl/ExecCore.sv ====
`timescale 1ns/1ps
`include "Core_cfg.svh"

module ExecCore (
    input  logic             clk,
    input  logic             rst,
    input  logic             instrValid,
    input  CorePkg::dataWord instr,
    input  CorePkg::regIndex readRegisterDebug,
    output logic             resultValid,
    output CorePkg::regIndex resultReg,
    output CorePkg::dataWord resultData,
    output logic             illegal,
    output CorePkg::dataWord readDataDebug
);
    import CorePkg::*;

    regIndex rs;
    regIndex rt;
    regIndex destReg;
    logic [4:0] shamt;
    AluOp aluOp;
    logic useImm;
    dataWord imm;
    logic legal;
    dataWord readData1;
    dataWord readData2;
    dataWord operandB;
    dataWord aluResult;
    logic writeEnable;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Datapath
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    InstrDecoder decoder (
        .instr(instr),
        .rs(rs),
        .rt(rt),
        .destReg(destReg),
        .shamt(shamt),
        .aluOp(aluOp),
        .useImm(useImm),
        .imm(imm),
        .legal(legal)
    );

    RegFile regFile (
        .clk(clk),
        .rst(rst),
        .readRegister1(rs),
        .readRegister2(rt),
        .writeRegister(destReg),
        .writeData(aluResult),
        .writeEnable(writeEnable),
        .readData1(readData1),
        .readData2(readData2),
        .readRegisterDebug(readRegisterDebug),
        .readDataDebug(readDataDebug)
    );

    assign operandB = useImm ? imm : readData2;

    Alu alu (
        .a(readData1),
        .b(operandB),
        .shamt(shamt),
        .aluOp(aluOp),
        .result(aluResult)
    );

    // Register 0 writes are dropped inside the register file.
    assign writeEnable = instrValid && legal;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Retire report, one cycle late
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            resultValid <= 1'b0;
            resultReg <= '0;
            resultData <= '0;
            illegal <= 1'b0;
        end else begin
            resultValid <= writeEnable;
            illegal <= instrValid && !legal;
            if (writeEnable) begin
                resultReg <= destReg;
                resultData <= aluResult;
            end
        end
    end

endmodule

// ==== tb/ExecCore_props.sv ====
`timescale 1ns/1ps

module ExecCore_props (
    input logic             clk,
    input logic             rst,
    input logic             instrValid,
    input logic             resultValid,
    input logic             illegal,
    input CorePkg::regIndex readRegisterDebug,
    input CorePkg::dataWord readDataDebug
);

    // Retire and reject never overlap.
    exclusiveReport: assert property (@(posedge clk) disable iff (rst)
        !(resultValid && illegal))
        else $error("resultValid and illegal are high in the same cycle");

    // No report without a strobe the cycle before.
    reportNeedsStrobe: assert property (@(posedge clk) disable iff (rst)
        !instrValid |=> !(resultValid || illegal))
        else $error("report raised without an instruction strobe");

    zeroDebugRead: assert property (@(posedge clk) disable iff (rst)
        readRegisterDebug == '0 |-> readDataDebug == '0)
        else $error("debug read of register 0 is not zero");

endmodule

bind ExecCore ExecCore_props props (
    .clk(clk),
    .rst(rst),
    .instrValid(instrValid),
    .resultValid(resultValid),
    .illegal(illegal),
    .readRegisterDebug(readRegisterDebug),
    .readDataDebug(readDataDebug)
);

// ==== tb/ExecCoreTb.sv ====
`timescale 1ns/1ps
`include "Core_cfg.svh"

module ExecCoreTb;
    import CorePkg::*;

    localparam int period = 8;
    localparam int testCount = 6;
    localparam int regCount = 1 << `REG_ADDR_WIDTH;

    logic clk = 1'b0;
    logic rst;
    logic instrValid;
    dataWord instr;
    regIndex readRegisterDebug;
    logic resultValid;
    regIndex resultReg;
    dataWord resultData;
    logic illegal;
    dataWord readDataDebug;

    // Expected architectural state.
    dataWord model [regCount];
    logic [31:0] rngState = 32'h67ac0ad9;
    int errors = 0;
    int testErrors = 0;
    int failedTests = 0;

    ExecCore UUT (.*);

    always #(period / 2) clk = ~clk;

    function automatic logic [31:0] nextRandom();
        logic [31:0] x;
        x = rngState;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rngState = x;
        return x;
    endfunction

    function automatic dataWord rType(input logic [5:0] fn, input regIndex rd,
                                      input regIndex rs, input regIndex rt,
                                      input logic [4:0] shamt);
        return {6'd0, rs, rt, rd, shamt, fn};
    endfunction

    function automatic dataWord iType(input logic [5:0] op, input regIndex rt,
                                      input regIndex rs, input logic [15:0] k);
        return {op, rs, rt, k};
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic void predict(input dataWord word, output logic isLegal,
                                    output regIndex dest, output dataWord value);
        dataWord a;
        dataWord b;
        logic [15:0] k;
        a = model[word[25:21]];
        b = model[word[20:16]];
        k = word[15:0];
        isLegal = 1'b1;
        dest = word[20:16];
        value = '0;
        case (word[31:26])
            OP_RTYPE: begin
                dest = word[15:11];
                case (word[5:0])
                    FN_ADD: value = a + b;
                    FN_SUB: value = a - b;
                    FN_AND: value = a & b;
                    FN_OR: value = a | b;
                    FN_XOR: value = a ^ b;
                    FN_SLT: value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    FN_SLL: value = b << word[10:6];
                    FN_SRL: value = b >> word[10:6];
                    default: isLegal = 1'b0;
                endcase
            end
            OP_ADDI: value = a + {{16{k[15]}}, k};
            OP_ANDI: value = a & {16'h0000, k};
            OP_ORI: value = a | {16'h0000, k};
            OP_LUI: value = {k, 16'h0000};
            default: isLegal = 1'b0;
        endcase
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Compare and report
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic checkWord(input string name, input dataWord expected, input dataWord actual);
        if (actual !== expected) begin
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
            testErrors++;
        end
    endtask

    task automatic checkReg(input string name, input regIndex expected, input regIndex actual);
        if (actual !== expected) begin
            $display("[FAIL] %s: expected r%0d, actual r%0d", name, expected, actual);
            testErrors++;
        end
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("[FAIL] %s: expected %b, actual %b", name, expected, actual);
            testErrors++;
        end
    endtask

    task automatic reportTest(input string name);
        if (testErrors == 0) begin
            $display("%s: passed", name);
        end else begin
            $display("%s: failed with %0d mismatches", name, testErrors);
            failedTests++;
        end
        errors += testErrors;
        testErrors = 0;
    endtask

    // Strobes one word per cycle, checks each retire one cycle later.
    task automatic runSequence(input string name, input dataWord words[$]);
        logic expLegal;
        regIndex expReg;
        dataWord expData;
        for (int i = 0; i <= words.size(); i++) begin
            @(posedge clk);
            if (i < words.size()) begin
                instrValid <= 1'b1;
                instr <= words[i];
            end else begin
                instrValid <= 1'b0;
            end
            @(negedge clk);
            if (i > 0) begin
                predict(words[i-1], expLegal, expReg, expData);
                checkFlag(name, expLegal, resultValid);
                checkFlag(name, !expLegal, illegal);
                if (expLegal) begin
                    checkReg(name, expReg, resultReg);
                    checkWord(name, expData, resultData);
                    if (expReg != '0) model[expReg] = expData;
                end
            end
        end
    endtask

    task automatic checkDebug(input string name, input regIndex index);
        @(posedge clk);
        readRegisterDebug <= index;
        @(negedge clk);
        checkWord(name, model[index], readDataDebug);
    endtask

    task automatic checkAllRegisters(input string name);
        for (int r = 0; r < regCount; r++) begin
            checkDebug(name, regIndex'(r));
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Directed tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic testReset();
        @(negedge clk);
        checkFlag("testReset", 1'b0, resultValid);
        checkFlag("testReset", 1'b0, illegal);
        checkAllRegisters("testReset");
        reportTest("testReset");
    endtask

    task automatic testZeroRegister();
        dataWord words [$];
        words.push_back(iType(OP_ADDI, 5'd0, 5'd0, 16'h1234));
        runSequence("testZeroRegister", words);
        checkDebug("testZeroRegister", 5'd0);
        reportTest("testZeroRegister");
    endtask

    task automatic testRtype();
        Funct functs [8] = '{FN_ADD, FN_SUB, FN_AND, FN_OR, FN_XOR, FN_SLT, FN_SLL, FN_SRL};
        dataWord words [$];
        dataWord value;
        logic [31:0] pick;
        regIndex rd;
        for (int r = 1; r <= 8; r++) begin
            value = nextRandom();
            words.push_back(iType(OP_LUI, regIndex'(r), 5'd0, value[31:16]));
            words.push_back(iType(OP_ORI, regIndex'(r), regIndex'(r), value[15:0]));
        end
        runSequence("testRtype", words);
        foreach (functs[f]) begin
            pick = nextRandom();
            rd = regIndex'(9 + f);
            words = {};
            words.push_back(rType(functs[f], rd, regIndex'(1 + pick[2:0]),
                                  regIndex'(1 + pick[5:3]), pick[10:6]));
            runSequence("testRtype", words);
            checkDebug("testRtype", rd);
        end
        reportTest("testRtype");
    endtask

    task automatic testImmediate();
        dataWord words [$];
        words.push_back(iType(OP_ADDI, 5'd20, 5'd1, 16'hfff0));
        words.push_back(iType(OP_ADDI, 5'd21, 5'd0, 16'h8000));
        words.push_back(iType(OP_ANDI, 5'd22, 5'd2, 16'hf0f0));
        words.push_back(iType(OP_ORI, 5'd23, 5'd3, 16'h8001));
        words.push_back(iType(OP_LUI, 5'd24, 5'd0, 16'hbeef));
        runSequence("testImmediate", words);
        for (int r = 20; r <= 24; r++) begin
            checkDebug("testImmediate", regIndex'(r));
        end
        reportTest("testImmediate");
    endtask

    // Each word reads the result of the one before.
    task automatic testBackToBack();
        dataWord words [$];
        words.push_back(iType(OP_ADDI, 5'd25, 5'd0, 16'h0005));
        words.push_back(rType(FN_ADD, 5'd26, 5'd25, 5'd25, 5'd0));
        words.push_back(rType(FN_SUB, 5'd27, 5'd26, 5'd1, 5'd0));
        words.push_back(rType(FN_SLL, 5'd28, 5'd0, 5'd27, 5'd3));
        words.push_back(rType(FN_XOR, 5'd25, 5'd28, 5'd26, 5'd0));
        words.push_back(rType(FN_SLT, 5'd29, 5'd25, 5'd27, 5'd0));
        runSequence("testBackToBack", words);
        reportTest("testBackToBack");
    endtask

    task automatic testIllegal();
        dataWord bad [2];
        dataWord words [$];
        bad[0] = iType(6'd63, 5'd5, 5'd1, 16'h1234);
        bad[1] = rType(6'd1, 5'd6, 5'd1, 5'd2, 5'd0);
        foreach (bad[i]) begin
            words = {};
            words.push_back(bad[i]);
            runSequence("testIllegal", words);
            @(negedge clk);
            checkFlag("testIllegal", 1'b0, illegal);
        end
        checkAllRegisters("testIllegal");
        reportTest("testIllegal");
    endtask

    initial begin
        rst = 1'b1;
        instrValid = 1'b0;
        instr = '0;
        readRegisterDebug = '0;
        for (int r = 0; r < regCount; r++) begin
            model[r] = '0;
        end
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        testReset();
        testZeroRegister();
        testRtype();
        testImmediate();
        testBackToBack();
        testIllegal();
        $display("Summary: %0d of %0d tests failed, %0d mismatches",
                 failedTests, testCount, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // Watchdog.
    initial begin
        #((testCount * 200 + 10) * period);
        $display("Timeout: the tests did not finish in the allowed time");
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+hdl
hdl/CorePkg.sv
hdl/RegFile.sv
hdl/InstrDecoder.sv
hdl/Alu.sv
hdl/ExecCore.sv
tb/ExecCore_props.sv
tb/ExecCoreTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS ?= --binary --timing --assert
TOP ?= ExecCoreTb
FILELIST ?= sources.f
BUILD_DIR ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(BUILD_DIR)
